// ==== rtl/aggre_pkg.sv ====
package aggre_pkg;

    // ===================================================================
    // Pipe geometry
    // ===================================================================
    localparam int unsigned PIPE_NUM   = 4;     // Video pipes into the aggregator
    localparam int unsigned PIPE_IDX_W = 2;     // Bits to address one pipe

    // ===================================================================
    // Aggregation mode
    // ===================================================================
    localparam int unsigned MODE_W = 2;

    // Concat mode, the only mode that updates the align fail status
    localparam logic [MODE_W-1:0] AGGRE_MODE_CONCAT = 2'd1;

    // ===================================================================
    // Data type
    // ===================================================================
    localparam int unsigned DT_WIDTH_DEF = 6;   // CSI-2 data type field

endpackage

// ==== rtl/sch_order_if.sv ====
`timescale 1ns/100ps

interface sch_order_if;
    import aggre_pkg::*;

    logic                  load;         // Accepted start, capture ready bits
    logic                  rotate;       // Ack taken, drop served entry
    logic [PIPE_IDX_W-1:0] rotate_sel;   // List position of the served entry
    logic                  pending;      // At least one entry left
    logic [PIPE_IDX_W-1:0] next_order;   // Pipe index of first valid entry
    logic [PIPE_IDX_W-1:0] first_pos;    // List position of first valid entry

    modport ctrl (
        output load, rotate, rotate_sel,
        input  pending, next_order, first_pos
    );

    modport rot (
        input  load, rotate, rotate_sel,
        output pending, next_order, first_pos
    );

endinterface

// ==== rtl/concat_sch_ctrl.sv ====
`timescale 1ns/100ps

module concat_sch_ctrl (
    input  logic                            aggre_clk,
    input  logic                            aggre_clk_rst_n,
    input  logic                            start_sch_pulse,
    input  logic [aggre_pkg::PIPE_IDX_W-1:0] master_pipe,
    input  logic [aggre_pkg::PIPE_NUM-1:0]  pipe_rdy_bitmap,
    input  logic                            out_comp_fail,
    input  logic [aggre_pkg::PIPE_NUM-1:0]  ack_concat,
    input  logic [aggre_pkg::PIPE_NUM-1:0]  line_end_concat,
    sch_order_if.ctrl                       order,
    output logic [aggre_pkg::PIPE_NUM-1:0]  grant,
    output logic                            end_sch_pulse
);
    import aggre_pkg::*;

    localparam logic [2:0] SCH_SILENT        = 3'd0;
    localparam logic [2:0] SCH_START         = 3'd1;
    localparam logic [2:0] SCH_MASTER        = 3'd2;
    localparam logic [2:0] SCH_ORDER         = 3'd3;
    localparam logic [2:0] SCH_WAIT_ACK      = 3'd4;
    localparam logic [2:0] SCH_CLEAR         = 3'd5;
    localparam logic [2:0] SCH_WAIT_LINE_END = 3'd6;

    logic [2:0] sch_cs;
    logic [2:0] sch_ns;
    logic       master_first;   // Master was ready at accept
    logic       master_flag;    // Master grant outstanding
    logic       start_acc;
    logic       ack_hit;
    logic       le_hit;
    logic       set_order;

    assign start_acc = start_sch_pulse & ~out_comp_fail;  // Blocked on data type mismatch
    assign ack_hit   = |(ack_concat & grant);             // Only the granted pipe counts
    assign le_hit    = |line_end_concat;

    // Next ordered grant, first one from START and the rest straight off a line end
    assign set_order = (sch_cs == SCH_ORDER) |
                       ((sch_cs == SCH_WAIT_LINE_END) & le_hit & order.pending);

    assign order.load       = (sch_cs == SCH_SILENT) & start_acc;
    assign order.rotate     = (sch_cs == SCH_WAIT_ACK) & ack_hit;
    assign order.rotate_sel = master_flag ? master_pipe : order.first_pos;

    // ===================================================================
    // Scheduling FSM
    // ===================================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_cs <= SCH_SILENT;
        end else begin
            sch_cs <= sch_ns;
        end
    end

    always_comb begin
        sch_ns = sch_cs;
        case (sch_cs)
            SCH_SILENT: begin
                if (start_acc) sch_ns = SCH_START;
            end
            SCH_START: begin
                if (master_first) begin
                    sch_ns = SCH_MASTER;
                end else if (order.pending) begin
                    sch_ns = SCH_ORDER;
                end else begin
                    sch_ns = SCH_SILENT;   // No pipe ready, round ends at once
                end
            end
            SCH_MASTER:   sch_ns = SCH_WAIT_ACK;
            SCH_ORDER:    sch_ns = SCH_WAIT_ACK;
            SCH_WAIT_ACK: begin
                if (ack_hit) sch_ns = SCH_CLEAR;
            end
            SCH_CLEAR:    sch_ns = SCH_WAIT_LINE_END;
            SCH_WAIT_LINE_END: begin
                if (le_hit) sch_ns = order.pending ? SCH_WAIT_ACK : SCH_SILENT;
            end
            default:      sch_ns = SCH_SILENT;
        endcase
    end

    // ===================================================================
    // Master tracking, grants and end pulse
    // ===================================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_first <= 1'b1;
            master_flag  <= 1'b0;
        end else begin
            if (order.load) master_first <= pipe_rdy_bitmap[master_pipe];
            if (sch_cs == SCH_MASTER) begin
                master_flag <= 1'b1;
            end else if (order.rotate) begin
                master_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            grant <= '0;
        end else if (sch_cs == SCH_MASTER) begin
            grant[master_pipe] <= 1'b1;
        end else if (set_order) begin
            grant[order.next_order] <= 1'b1;
        end else if (order.rotate) begin
            grant <= '0;                   // Grant drops with the ack
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            end_sch_pulse <= 1'b0;
        end else begin
            end_sch_pulse <= ((sch_cs == SCH_WAIT_LINE_END) & le_hit & ~order.pending) |
                             ((sch_cs == SCH_START) & ~master_first & ~order.pending);
        end
    end

endmodule

// ==== rtl/order_rotator.sv ====
`timescale 1ns/100ps

module order_rotator (
    input  logic                           aggre_clk,
    input  logic                           aggre_clk_rst_n,
    input  logic [aggre_pkg::PIPE_NUM-1:0] pipe_rdy_bitmap,
    sch_order_if.rot                       order
);
    import aggre_pkg::*;

    logic [PIPE_NUM-1:0]   ent_vld;                // Entry still to be served
    logic [PIPE_IDX_W-1:0] ent_idx [PIPE_NUM];     // Pipe held by each entry
    logic [PIPE_IDX_W-1:0] rot_src [PIPE_NUM-1];   // Source slot per new front slot
    logic [PIPE_IDX_W-1:0] first_pos;
    logic                  found;

    // First valid entry by priority, slot 0 highest
    always_comb begin
        first_pos = '0;
        found     = 1'b0;
        for (int i = 0; i < PIPE_NUM; i++) begin
            if (ent_vld[i] && !found) begin
                first_pos = PIPE_IDX_W'(i);
                found     = 1'b1;
            end
        end
    end

    assign order.pending    = |ent_vld;
    assign order.first_pos  = first_pos;
    assign order.next_order = ent_idx[first_pos];

    // Entries after the served slot come first, then the ones before it
    always_comb begin
        for (int k = 0; k < PIPE_NUM - 1; k++) begin
            rot_src[k] = order.rotate_sel + PIPE_IDX_W'(k + 1);   // Wraps 3 -> 0
        end
    end

    // ===================================================================
    // Pending order list
    // ===================================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            ent_vld <= '0;
            for (int i = 0; i < PIPE_NUM; i++) begin
                ent_idx[i] <= PIPE_IDX_W'(i);
            end
        end else if (order.load) begin
            ent_vld <= pipe_rdy_bitmap;            // Slot i holds pipe i
            for (int i = 0; i < PIPE_NUM; i++) begin
                ent_idx[i] <= PIPE_IDX_W'(i);
            end
        end else if (order.rotate) begin
            for (int k = 0; k < PIPE_NUM - 1; k++) begin
                ent_vld[k] <= ent_vld[rot_src[k]];
                ent_idx[k] <= ent_idx[rot_src[k]];
            end
            // Served entry parks at the tail
            ent_vld[PIPE_NUM-1] <= 1'b0;
            ent_idx[PIPE_NUM-1] <= ent_idx[order.rotate_sel];
        end
    end

endmodule

// ==== rtl/dt_align_cmp.sv ====
`timescale 1ns/100ps

module dt_align_cmp #(
    parameter int unsigned DT_WIDTH = aggre_pkg::DT_WIDTH_DEF
) (
    input  logic                           aggre_clk,
    input  logic                           aggre_clk_rst_n,
    input  logic [aggre_pkg::MODE_W-1:0]   aggre_mode,
    input  logic                           start_sch_pulse,
    input  logic [aggre_pkg::PIPE_NUM-1:0] pipe_rdy_bitmap,
    input  logic [aggre_pkg::PIPE_NUM-1:0] dt_vld,
    input  logic [DT_WIDTH-1:0]            dt0,
    input  logic [DT_WIDTH-1:0]            dt1,
    input  logic [DT_WIDTH-1:0]            dt2,
    input  logic [DT_WIDTH-1:0]            dt3,
    output logic                           out_comp_fail,
    output logic                           sch_data_type_align_fail_int
);
    import aggre_pkg::*;

    logic [PIPE_NUM-1:0] part;              // Pipes taking part in the compare
    logic [DT_WIDTH-1:0] dt_arr [PIPE_NUM];

    assign part = {PIPE_NUM{start_sch_pulse}} & pipe_rdy_bitmap & dt_vld;

    assign dt_arr[0] = dt0;
    assign dt_arr[1] = dt1;
    assign dt_arr[2] = dt2;
    assign dt_arr[3] = dt3;

    // Any differing pair among participants fails the round
    always_comb begin
        out_comp_fail = 1'b0;
        for (int i = 0; i < PIPE_NUM - 1; i++) begin
            for (int j = i + 1; j < PIPE_NUM; j++) begin
                if (part[i] && part[j] && (dt_arr[i] != dt_arr[j])) begin
                    out_comp_fail = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_data_type_align_fail_int <= 1'b0;
        end else if (aggre_mode == AGGRE_MODE_CONCAT) begin
            sch_data_type_align_fail_int <= out_comp_fail;   // Held in other modes
        end
    end

endmodule

// ==== rtl/pipe_src_router.sv ====
`timescale 1ns/100ps

module pipe_src_router (
    input  logic                           aggre_clk,
    input  logic                           aggre_clk_rst_n,
    input  logic [aggre_pkg::PIPE_NUM-1:0] pipe_mask_bitmap,
    input  logic [aggre_pkg::PIPE_NUM-1:0] concat_en,
    input  logic [aggre_pkg::PIPE_NUM-1:0] ack,
    input  logic [aggre_pkg::PIPE_NUM-1:0] line_end,
    input  logic                           bpg_ack,
    input  logic                           bpg_line_end,
    input  logic [aggre_pkg::PIPE_NUM-1:0] grant,
    output logic [aggre_pkg::PIPE_NUM-1:0] ack_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0] line_end_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0] up_state_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0] bpg_up_state,
    output logic [aggre_pkg::PIPE_NUM-1:0] bpg_ack_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0] bpg_line_end_concat
);
    import aggre_pkg::*;

    logic [PIPE_NUM-1:0] ack_sel;
    logic [PIPE_NUM-1:0] line_end_sel;

    // ===================================================================
    // Feedback select, masked pipes are answered by the BPG
    // ===================================================================
    always_comb begin
        for (int i = 0; i < PIPE_NUM; i++) begin
            ack_sel[i]      = pipe_mask_bitmap[i] ? bpg_ack      : ack[i];
            line_end_sel[i] = pipe_mask_bitmap[i] ? bpg_line_end : line_end[i];
        end
    end

    // To the scheduler, only concat enabled pipes
    assign ack_concat      = ack_sel & concat_en;
    assign line_end_concat = line_end_sel & concat_en;

    // Back to the BPG, only for the pipes it stands in for
    assign bpg_ack_concat      = ack_sel & pipe_mask_bitmap;
    assign bpg_line_end_concat = line_end_sel & pipe_mask_bitmap;

    // ===================================================================
    // Grant split between video pipes and BPG
    // ===================================================================
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            up_state_concat <= '0;
            bpg_up_state    <= '0;
        end else begin
            up_state_concat <= grant & ~pipe_mask_bitmap;
            bpg_up_state    <= grant & pipe_mask_bitmap;
        end
    end

endmodule

// ==== rtl/concat_sch_top.sv ====
`timescale 1ns/100ps

module concat_sch_top #(
    parameter int unsigned DT_WIDTH = aggre_pkg::DT_WIDTH_DEF
) (
    input  logic                             aggre_clk,
    input  logic                             aggre_clk_rst_n,
    input  logic [aggre_pkg::MODE_W-1:0]     aggre_mode,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   concat_en,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   pipe_mask_bitmap,
    input  logic [aggre_pkg::PIPE_IDX_W-1:0] master_pipe,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   pipe_rdy_bitmap,
    input  logic                             start_sch_pulse,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   dt_vld,
    input  logic [DT_WIDTH-1:0]              dt0,
    input  logic [DT_WIDTH-1:0]              dt1,
    input  logic [DT_WIDTH-1:0]              dt2,
    input  logic [DT_WIDTH-1:0]              dt3,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   ack,
    input  logic [aggre_pkg::PIPE_NUM-1:0]   line_end,
    input  logic                             bpg_empty,      // BPG status, not used here
    input  logic                             bpg_ack,
    input  logic                             bpg_line_end,
    output logic                             end_sch_pulse,
    output logic [aggre_pkg::PIPE_NUM-1:0]   up_state_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0]   bpg_up_state,
    output logic [aggre_pkg::PIPE_NUM-1:0]   bpg_ack_concat,
    output logic [aggre_pkg::PIPE_NUM-1:0]   bpg_line_end_concat,
    output logic                             sch_data_type_align_fail_int
);
    import aggre_pkg::*;

    logic                out_comp_fail;
    logic [PIPE_NUM-1:0] ack_concat;
    logic [PIPE_NUM-1:0] line_end_concat;
    logic [PIPE_NUM-1:0] grant;           // Internal grant before the mask split

    sch_order_if order_if ();

    concat_sch_ctrl u_ctrl (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .start_sch_pulse (start_sch_pulse),
        .master_pipe     (master_pipe),
        .pipe_rdy_bitmap (pipe_rdy_bitmap),
        .out_comp_fail   (out_comp_fail),
        .ack_concat      (ack_concat),
        .line_end_concat (line_end_concat),
        .order           (order_if.ctrl),
        .grant           (grant),
        .end_sch_pulse   (end_sch_pulse)
    );

    order_rotator u_rotator (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .pipe_rdy_bitmap (pipe_rdy_bitmap),
        .order           (order_if.rot)
    );

    dt_align_cmp #(
        .DT_WIDTH (DT_WIDTH)
    ) u_dt_cmp (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .aggre_mode                   (aggre_mode),
        .start_sch_pulse              (start_sch_pulse),
        .pipe_rdy_bitmap              (pipe_rdy_bitmap),
        .dt_vld                       (dt_vld),
        .dt0                          (dt0),
        .dt1                          (dt1),
        .dt2                          (dt2),
        .dt3                          (dt3),
        .out_comp_fail                (out_comp_fail),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    pipe_src_router u_router (
        .aggre_clk           (aggre_clk),
        .aggre_clk_rst_n     (aggre_clk_rst_n),
        .pipe_mask_bitmap    (pipe_mask_bitmap),
        .concat_en           (concat_en),
        .ack                 (ack),
        .line_end            (line_end),
        .bpg_ack             (bpg_ack),
        .bpg_line_end        (bpg_line_end),
        .grant               (grant),
        .ack_concat          (ack_concat),
        .line_end_concat     (line_end_concat),
        .up_state_concat     (up_state_concat),
        .bpg_up_state        (bpg_up_state),
        .bpg_ack_concat      (bpg_ack_concat),
        .bpg_line_end_concat (bpg_line_end_concat)
    );

endmodule

// ==== dv/sch_checker.sv ====
`timescale 1ns/100ps

module sch_checker (
    input  logic        aggre_clk,
    input  logic        aggre_clk_rst_n,
    input  logic [3:0]  up_state_concat,
    input  logic [3:0]  bpg_up_state,
    input  logic        end_sch_pulse,
    input  logic [3:0]  bpg_ack_concat,
    input  logic [3:0]  bpg_line_end_concat,
    input  logic        sch_data_type_align_fail_int,
    input  logic [3:0]  pipe_mask_bitmap,
    input  logic        bpg_ack,
    input  logic        bpg_line_end,
    input  logic [7:0]  exp_seq,         // Two bits per grant with the first grant low
    input  int          exp_len,
    input  int          exp_end,
    input  logic        exp_fail,
    input  logic        round_close,
    output int          err_cnt
);
    logic [3:0] g_prev;
    logic [3:0] g_now;
    logic [3:0] rise;
    int         n_grant;
    int         n_end;

    assign g_now = up_state_concat | bpg_up_state;
    assign rise  = g_now & ~g_prev;

    function automatic int pipe_of(input logic [3:0] g);
        int idx;
        idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (g[i]) idx = i;
        end
        return idx;
    endfunction

    // Sampled mid-cycle where all DUT outputs have settled
    always @(negedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            g_prev  <= '0;
            n_grant <= 0;
            n_end   <= 0;
            err_cnt = 0;
        end else begin
            g_prev <= g_now;
            if ($countones(g_now) > 1) begin
                $display("** Error at %0t: grant one-hot got %b exp one at most", $time, g_now);
                err_cnt = err_cnt + 1;
            end
            if (rise != 4'b0) begin
                if (n_grant >= exp_len) begin
                    $display("Unexpected grant to pipe %0d at %0t", pipe_of(rise), $time);
                    err_cnt = err_cnt + 1;
                end else if (pipe_of(rise) != int'(exp_seq[2*n_grant +: 2])) begin
                    $display("** Error at %0t: grant order got %0d exp %0d", $time,
                             pipe_of(rise), exp_seq[2*n_grant +: 2]);
                    err_cnt = err_cnt + 1;
                end
                if ((bpg_up_state & rise) != (rise & pipe_mask_bitmap)) begin
                    $display("** Error at %0t: bpg_up_state got %b exp %b", $time,
                             bpg_up_state & rise, rise & pipe_mask_bitmap);
                    err_cnt = err_cnt + 1;
                end
                n_grant <= n_grant + 1;
            end
            // Masked pipes are never granted on the video side
            if ((up_state_concat & pipe_mask_bitmap) != 4'b0) begin
                $display("** Error at %0t: up_state_concat got %b exp %b", $time,
                         up_state_concat, up_state_concat & ~pipe_mask_bitmap);
                err_cnt = err_cnt + 1;
            end
            if (bpg_ack_concat != ({4{bpg_ack}} & pipe_mask_bitmap)) begin
                $display("** Error at %0t: bpg_ack_concat got %b exp %b", $time,
                         bpg_ack_concat, {4{bpg_ack}} & pipe_mask_bitmap);
                err_cnt = err_cnt + 1;
            end
            if (bpg_line_end_concat != ({4{bpg_line_end}} & pipe_mask_bitmap)) begin
                $display("** Error at %0t: bpg_line_end_concat got %b exp %b", $time,
                         bpg_line_end_concat, {4{bpg_line_end}} & pipe_mask_bitmap);
                err_cnt = err_cnt + 1;
            end
            if (sch_data_type_align_fail_int != exp_fail) begin
                $display("** Error at %0t: sch_data_type_align_fail_int got %b exp %b",
                         $time, sch_data_type_align_fail_int, exp_fail);
                err_cnt = err_cnt + 1;
            end
            if (round_close) begin
                if (n_grant != exp_len) begin
                    $display("Round closed after %0d grants, %0d were due", n_grant, exp_len);
                    err_cnt = err_cnt + 1;
                end
                if (n_end + int'(end_sch_pulse) != exp_end) begin
                    $display("** Error at %0t: end_sch_pulse count got %0d exp %0d", $time,
                             n_end + int'(end_sch_pulse), exp_end);
                    err_cnt = err_cnt + 1;
                end
                n_grant <= 0;
                n_end   <= 0;
            end else if (end_sch_pulse) begin
                n_end <= n_end + 1;
            end
        end
    end

endmodule

// ==== dv/tb_concat_sch.sv ====
`timescale 1ns/100ps

module tb_concat_sch;
    import aggre_pkg::*;

    localparam int unsigned DT_W        = DT_WIDTH_DEF;
    localparam int unsigned SEED        = 32'hc01f_b626;
    localparam int          ROUND_CYC   = 90;            // Worst case for one round
    localparam int          ROUND_NUM   = 53;            // Tests 2 to 6
    localparam int          CYCLE_LIMIT = ROUND_NUM * ROUND_CYC + 240;

    logic                  aggre_clk;
    logic                  aggre_clk_rst_n;
    logic [MODE_W-1:0]     aggre_mode;
    logic [PIPE_NUM-1:0]   concat_en;
    logic [PIPE_NUM-1:0]   pipe_mask_bitmap;
    logic [PIPE_IDX_W-1:0] master_pipe;
    logic [PIPE_NUM-1:0]   pipe_rdy_bitmap;
    logic                  start_sch_pulse;
    logic [PIPE_NUM-1:0]   dt_vld;
    logic [DT_W-1:0]       dt0;
    logic [DT_W-1:0]       dt1;
    logic [DT_W-1:0]       dt2;
    logic [DT_W-1:0]       dt3;
    logic [PIPE_NUM-1:0]   ack;
    logic [PIPE_NUM-1:0]   line_end;
    logic                  bpg_empty;
    logic                  bpg_ack;
    logic                  bpg_line_end;
    logic                  end_sch_pulse;
    logic [PIPE_NUM-1:0]   up_state_concat;
    logic [PIPE_NUM-1:0]   bpg_up_state;
    logic [PIPE_NUM-1:0]   bpg_ack_concat;
    logic [PIPE_NUM-1:0]   bpg_line_end_concat;
    logic                  sch_data_type_align_fail_int;

    logic [7:0] exp_seq;
    int         exp_len;
    int         exp_end;
    int         err_cnt;
    int         cycle_cnt;
    int         fail_tests;
    int         pass_tests;
    int         err_mark;
    logic       exp_fail;
    logic       round_close;

    concat_sch_top #(.DT_WIDTH(DT_W)) concat_sch_top_i (.*);

    sch_checker sch_checker_i (.*);

    initial aggre_clk = 1'b0;
    always #4 aggre_clk = ~aggre_clk;

    // Run limit
    always @(posedge aggre_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ===================================================================
    // Reference model
    // ===================================================================
    function automatic void expected_order(input logic [3:0] rdy, input logic [1:0] m,
                                           output logic [7:0] seq, output int len);
        int p;
        seq = '0;
        len = 0;
        for (int k = 0; k < 4; k++) begin
            p = rdy[m] ? (int'(m) + k) % 4 : k;   // Wrap after master or count up from 0
            if (rdy[p]) begin
                seq[2*len +: 2] = 2'(p);
                len = len + 1;
            end
        end
    endfunction

    function automatic logic dt_mismatch(input logic [3:0] part);
        logic [DT_W-1:0] d [4];
        logic            bad;
        d[0] = dt0;
        d[1] = dt1;
        d[2] = dt2;
        d[3] = dt3;
        bad  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (part[i] && part[j] && d[i] != d[j]) bad = 1'b1;
            end
        end
        return bad;
    endfunction

    // Pipe and BPG answer each grant with an ack and then a line end
    initial begin : pipe_model
        logic [3:0]  g;
        int          idx;
        logic        by_bpg;
        int unsigned d;
        forever begin
            @(posedge aggre_clk);
            #1;
            g = up_state_concat | bpg_up_state;
            if (g != 4'b0) begin
                idx = 0;
                for (int i = 0; i < 4; i++) begin
                    if (g[i]) idx = i;
                end
                by_bpg = |bpg_up_state;
                d = $urandom_range(4, 1);
                repeat (d) @(posedge aggre_clk);
                #1;
                if (by_bpg) bpg_ack = 1'b1;
                else ack[idx] = 1'b1;
                @(posedge aggre_clk);
                #1;
                bpg_ack = 1'b0;
                ack     = '0;
                d = $urandom_range(6, 1);
                repeat (d) @(posedge aggre_clk);
                #1;
                if (by_bpg) bpg_line_end = 1'b1;
                else line_end[idx] = 1'b1;
                @(posedge aggre_clk);
                #1;
                bpg_line_end = 1'b0;
                line_end     = '0;
            end
        end
    end

    task automatic close_round();
        round_close = 1'b1;
        @(posedge aggre_clk);
        #1;
        round_close = 1'b0;
    endtask

    task automatic run_round(input logic [3:0] rdy, input logic [1:0] mst,
                             input logic [3:0] msk, input logic [3:0] vld,
                             input logic [MODE_W-1:0] mode);
        logic [7:0] seq;
        int         len;
        logic       blocked;
        expected_order(rdy, mst, seq, len);
        blocked          = dt_mismatch(rdy & vld);
        pipe_rdy_bitmap  = rdy;
        master_pipe      = mst;
        pipe_mask_bitmap = msk;
        dt_vld           = vld;
        exp_seq          = blocked ? 8'h0 : seq;
        exp_len          = blocked ? 0 : len;
        exp_end          = blocked ? 0 : 1;
        aggre_mode       = mode;
        start_sch_pulse  = 1'b1;
        @(posedge aggre_clk);
        #1;
        start_sch_pulse = 1'b0;
        aggre_mode      = '0;                // Flag held until the next concat start
        if (mode == AGGRE_MODE_CONCAT) exp_fail = blocked;
        if (blocked) begin
            repeat (12) @(posedge aggre_clk);
            #1;
        end else begin
            do begin
                @(posedge aggre_clk);
                #1;
            end while (!end_sch_pulse);
            repeat (2) @(posedge aggre_clk);
            #1;
        end
        close_round();
    endtask

    task automatic report_test(input int id, input string name);
        if (err_cnt == err_mark) begin
            pass_tests++;
            $display("Test %0d %s: passed", id, name);
        end else begin
            fail_tests++;
            $display("Test %0d %s: failed with %0d errors", id, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // ===================================================================
    // Stimulus
    // ===================================================================
    initial begin
        logic [DT_W-1:0] v;
        void'($urandom(SEED));
        cycle_cnt = 0;
        pass_tests = 0;
        fail_tests = 0;
        err_mark = 0;
        aggre_clk_rst_n = 1'b0;
        aggre_mode = '0;
        concat_en = 4'hf;
        pipe_mask_bitmap = '0;
        master_pipe = '0;
        pipe_rdy_bitmap = '0;
        start_sch_pulse = 1'b0;
        dt_vld = '0;
        {dt0, dt1, dt2, dt3} = '0;
        ack = '0;
        line_end = '0;
        bpg_empty = 1'b1;
        bpg_ack = 1'b0;
        bpg_line_end = 1'b0;
        exp_seq = '0;
        exp_len = 0;
        exp_end = 0;
        exp_fail = 1'b0;
        round_close = 1'b0;
        repeat (10) @(posedge aggre_clk);
        #1;
        aggre_clk_rst_n = 1'b1;

        repeat (20) @(posedge aggre_clk);
        #1;
        close_round();
        report_test(1, "idle after reset");

        for (int m = 0; m < 4; m++) begin
            run_round(4'hf, 2'(m), 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        end
        report_test(2, "master first");

        run_round(4'b1010, 2'd0, 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        run_round(4'b0110, 2'd3, 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        run_round(4'b1101, 2'd1, 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        report_test(3, "master not ready");

        run_round(4'hf, 2'd1, 4'b0101, 4'hf, AGGRE_MODE_CONCAT);
        run_round(4'b1011, 2'd3, 4'b1000, 4'hf, AGGRE_MODE_CONCAT);
        run_round(4'hf, 2'd2, 4'hf, 4'hf, AGGRE_MODE_CONCAT);
        report_test(4, "masked pipes on BPG");

        dt2 = 6'h2b;                         // One pipe off the common type
        run_round(4'hf, 2'd0, 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        dt2 = 6'h00;
        run_round(4'hf, 2'd1, 4'h0, 4'hf, '0);
        run_round(4'hf, 2'd2, 4'h0, 4'hf, AGGRE_MODE_CONCAT);
        report_test(5, "data type mismatch");

        for (int r = 0; r < 40; r++) begin
            v = DT_W'($urandom);
            {dt0, dt1, dt2, dt3} = {v, v, v, v};
            if ($urandom_range(1, 0) == 1) begin
                {dt0, dt1, dt2, dt3} = (4 * DT_W)'($urandom);
            end
            run_round(4'($urandom), 2'($urandom), 4'($urandom), 4'($urandom),
                      ($urandom_range(1, 0) == 1) ? AGGRE_MODE_CONCAT : 2'd0);
        end
        report_test(6, "random rounds");

        $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/aggre_pkg.sv
rtl/sch_order_if.sv
rtl/concat_sch_ctrl.sv
rtl/order_rotator.sv
rtl/dt_align_cmp.sv
rtl/pipe_src_router.sv
rtl/concat_sch_top.sv
dv/sch_checker.sv
dv/tb_concat_sch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_concat_sch \
    -f flist.f \
    -o sim_concat_sch

./obj_dir/sim_concat_sch > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
